// File: design/alu.sv
module alu
	import cpu_pkg::*;
(
	input  alu_op_t                  i_alu_op,
	input  logic [CPU_REG_WIDTH-1:0] i_a,
	input  logic [CPU_REG_WIDTH-1:0] i_b,
	output logic [CPU_REG_WIDTH-1:0] o_result
);

	logic [4:0] shamt;			// shift amount from low bits of b.
	logic       lt_signed;		// a < b as two's complement.
	logic       lt_unsigned;	// a < b as magnitudes.

	assign shamt       = i_b[4:0];
	assign lt_signed   = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	always_comb
	begin
		case (i_alu_op)
			ALU_ADD:
				o_result = i_a + i_b;
			ALU_SUB:
				o_result = i_a - i_b;
			ALU_AND:
				o_result = i_a & i_b;
			ALU_OR:
				o_result = i_a | i_b;
			ALU_XOR:
				o_result = i_a ^ i_b;
			ALU_NOR:
				o_result = ~(i_a | i_b);
			ALU_SLT:
				o_result = {{(CPU_REG_WIDTH-1){1'b0}}, lt_signed};	// zero extended flag.
			ALU_SLTU:
				o_result = {{(CPU_REG_WIDTH-1){1'b0}}, lt_unsigned};
			ALU_SLL:
				o_result = i_a << shamt;
			ALU_SRL:
				o_result = i_a >> shamt;	// fills with zeros.
			ALU_SRA:
				o_result = $signed(i_a) >>> shamt;	// fills with sign.
			ALU_LUI:
				o_result = {i_b[15:0], 16'h0000};	// low half cleared.
			default:
				o_result = i_a + i_b;	// unused codes behave as add.
		endcase
	end

endmodule

// File: design/branch_unit.sv
module branch_unit
	import cpu_pkg::*;
(
	input  jump_t                    i_jump,
	input  logic [CPU_REG_WIDTH-1:0] i_rs_val,
	input  logic [CPU_REG_WIDTH-1:0] i_rt_val,
	output logic                     o_taken
);

	logic rs_neg;	// sign bit of rs.
	logic rs_zero;	// rs is all zeros.
	logic rs_eq_rt;	// operands compare equal.

	assign rs_neg   = i_rs_val[CPU_REG_WIDTH-1];
	assign rs_zero  = ~|i_rs_val;
	assign rs_eq_rt = i_rs_val == i_rt_val;

	always_comb
	begin
		case (i_jump)
			JMP_J, JMP_JR:
				o_taken = 1'b1;	// unconditional.
			JMP_BLTZ:
				o_taken = rs_neg;
			JMP_BGEZ:
				o_taken = ~rs_neg;
			JMP_BEQ:
				o_taken = rs_eq_rt;
			JMP_BNE:
				o_taken = ~rs_eq_rt;
			JMP_BLEZ:
				o_taken = rs_neg | rs_zero;
			JMP_BGTZ:
				o_taken = ~rs_neg & ~rs_zero;
			default:
				o_taken = 1'b0;	// JMP_NONE and unused codes.
		endcase
	end

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

	localparam int CPU_REG_WIDTH   = 32;	// general register width.
	localparam int CPU_ADDR_WIDTH  = 32;	// byte address width.
	localparam int CPU_REGNO_WIDTH = 5;	// register number width.

	localparam int DMEM_AW    = 8;		// data RAM word address bits.
	localparam int DMEM_WORDS = 256;	// data RAM depth in words.

	// writes to r0 are discarded by the register file
	localparam logic [CPU_REGNO_WIDTH-1:0] REG_R0 = '0;

	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'd0,	// a + b.
		ALU_SUB  = 4'd1,	// a - b.
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,	// signed less than.
		ALU_SLTU = 4'd7,	// unsigned less than.
		ALU_SLL  = 4'd8,	// a shifted by b[4:0].
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,	// keeps sign of a.
		ALU_LUI  = 4'd11	// b moved to upper half.
	} alu_op_t;

	typedef enum logic [2:0]
	{
		INPT_RSRT  = 3'd0,	// a = rs, b = rt.
		INPT_RTRS  = 3'd1,	// a = rt, b = rs.
		INPT_RSIMM = 3'd2,	// a = rs, b = imm.
		INPT_RTIMM = 3'd3,	// a = rt, b = imm.
		INPT_PCIMM = 3'd4	// a = pc_p1, b = imm.
	} alu_inpt_t;

	typedef enum logic [3:0]
	{
		JMP_NONE = 4'd0,	// not a control transfer.
		JMP_J    = 4'd1,	// unconditional, pc relative.
		JMP_JR   = 4'd2,	// unconditional, register target.
		JMP_BLTZ = 4'd3,
		JMP_BGEZ = 4'd4,
		JMP_BEQ  = 4'd5,
		JMP_BNE  = 4'd6,
		JMP_BLEZ = 4'd7,
		JMP_BGTZ = 4'd8
	} jump_t;

	typedef enum logic [2:0]
	{
		LSU_IDLE = 3'd0,	// no memory access.
		LSU_LB   = 3'd1,
		LSU_LH   = 3'd2,
		LSU_LW   = 3'd3,
		LSU_SB   = 3'd4,
		LSU_SH   = 3'd5,
		LSU_SW   = 3'd6
	} lsu_op_t;

endpackage

// File: design/data_ram.sv
module data_ram
	import cpu_pkg::*;
(
	input  logic                     clk,
	input  logic [DMEM_AW-1:0]       i_addr,
	input  logic [3:0]               i_be,
	input  logic                     i_we,
	input  logic [CPU_REG_WIDTH-1:0] i_wdata,
	output logic [CPU_REG_WIDTH-1:0] o_rdata
);

	logic [CPU_REG_WIDTH-1:0] mem [DMEM_WORDS];	// word array.

	// byte lanes written independently
	always_ff @(posedge clk)
	begin
		if (i_we)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (i_be[i])
					mem[i_addr][8*i +: 8] <= i_wdata[8*i +: 8];
			end
		end
	end

	assign o_rdata = mem[i_addr];	// asynchronous read.

endmodule

// File: design/exec_mem_top.sv
module exec_mem_top
	import cpu_pkg::*;
(
	input  logic                       clk,
	input  logic                       nrst,
	input  logic [CPU_ADDR_WIDTH-1:0]  i_pc_p0,
	input  logic [CPU_ADDR_WIDTH-1:0]  i_pc_p1,
	input  logic                       i_stall,
	input  logic                       i_drop,
	input  logic [CPU_REGNO_WIDTH-1:0] i_rd_no,
	input  logic [CPU_REG_WIDTH-1:0]   i_rs_val,
	input  logic [CPU_REG_WIDTH-1:0]   i_rt_val,
	input  logic [CPU_REG_WIDTH-1:0]   i_imm,
	input  alu_op_t                    i_alu_op,
	input  alu_inpt_t                  i_alu_inpt,
	input  jump_t                      i_jump,
	input  logic                       i_jump_link,
	input  lsu_op_t                    i_lsu_op,
	input  logic                       i_lsu_ext,
	output logic                       o_jump_valid,
	output logic [CPU_ADDR_WIDTH-1:0]  o_jump_addr,
	output logic [CPU_REGNO_WIDTH-1:0] o_wb_rd_no,
	output logic [CPU_REG_WIDTH-1:0]   o_wb_data
);

	logic [CPU_REGNO_WIDTH-1:0] ex_rd_no;		// execute to memory stage.
	logic [CPU_REG_WIDTH-1:0]   ex_alu_result;
	lsu_op_t                    ex_lsu_op;
	logic                       ex_lsu_ext;
	logic [CPU_REG_WIDTH-1:0]   ex_mem_data;
	logic [DMEM_AW-1:0]         ram_addr;		// memory stage to RAM.
	logic [3:0]                 ram_be;
	logic                       ram_we;
	logic [CPU_REG_WIDTH-1:0]   ram_wdata;
	logic [CPU_REG_WIDTH-1:0]   ram_rdata;

	execute u_execute
	(
		.clk          (clk),
		.nrst         (nrst),
		.i_pc_p0      (i_pc_p0),
		.i_pc_p1      (i_pc_p1),
		.i_stall      (i_stall),
		.i_drop       (i_drop),
		.i_rd_no      (i_rd_no),
		.i_rs_val     (i_rs_val),
		.i_rt_val     (i_rt_val),
		.i_imm        (i_imm),
		.i_alu_op     (i_alu_op),
		.i_alu_inpt   (i_alu_inpt),
		.i_jump       (i_jump),
		.i_jump_link  (i_jump_link),
		.i_lsu_op     (i_lsu_op),
		.i_lsu_ext    (i_lsu_ext),
		.o_rd_no      (ex_rd_no),
		.o_alu_result (ex_alu_result),
		.o_jump_addr  (o_jump_addr),
		.o_jump_valid (o_jump_valid),
		.o_lsu_op     (ex_lsu_op),
		.o_lsu_ext    (ex_lsu_ext),
		.o_mem_data   (ex_mem_data)
	);

	lsu_stage u_lsu_stage
	(
		.clk          (clk),
		.nrst         (nrst),
		.i_stall      (i_stall),
		.i_rd_no      (ex_rd_no),
		.i_alu_result (ex_alu_result),
		.i_lsu_op     (ex_lsu_op),
		.i_lsu_ext    (ex_lsu_ext),
		.i_mem_data   (ex_mem_data),
		.i_rdata      (ram_rdata),
		.o_addr       (ram_addr),
		.o_be         (ram_be),
		.o_we         (ram_we),
		.o_wdata      (ram_wdata),
		.o_wb_rd_no   (o_wb_rd_no),
		.o_wb_data    (o_wb_data)
	);

	data_ram u_data_ram
	(
		.clk     (clk),
		.i_addr  (ram_addr),
		.i_be    (ram_be),
		.i_we    (ram_we),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

endmodule

// File: design/execute.sv
module execute
	import cpu_pkg::*;
(
	input  logic                       clk,
	input  logic                       nrst,
	input  logic [CPU_ADDR_WIDTH-1:0]  i_pc_p0,
	input  logic [CPU_ADDR_WIDTH-1:0]  i_pc_p1,
	input  logic                       i_stall,
	input  logic                       i_drop,
	input  logic [CPU_REGNO_WIDTH-1:0] i_rd_no,
	input  logic [CPU_REG_WIDTH-1:0]   i_rs_val,
	input  logic [CPU_REG_WIDTH-1:0]   i_rt_val,
	input  logic [CPU_REG_WIDTH-1:0]   i_imm,
	input  alu_op_t                    i_alu_op,
	input  alu_inpt_t                  i_alu_inpt,
	input  jump_t                      i_jump,
	input  logic                       i_jump_link,
	input  lsu_op_t                    i_lsu_op,
	input  logic                       i_lsu_ext,
	output logic [CPU_REGNO_WIDTH-1:0] o_rd_no,
	output logic [CPU_REG_WIDTH-1:0]   o_alu_result,
	output logic [CPU_ADDR_WIDTH-1:0]  o_jump_addr,
	output logic                       o_jump_valid,
	output lsu_op_t                    o_lsu_op,
	output logic                       o_lsu_ext,
	output logic [CPU_REG_WIDTH-1:0]   o_mem_data
);

	alu_op_t                    alu_op;			// registered ALU operation.
	logic [CPU_REG_WIDTH-1:0]   a;				// registered first operand.
	logic [CPU_REG_WIDTH-1:0]   b;				// registered second operand.
	logic [CPU_REG_WIDTH-1:0]   alu_result;
	logic [CPU_REGNO_WIDTH-1:0] rd_no;			// captured destination.
	logic                       jump_instr;		// instruction is a jump or branch.
	logic                       branch_taken;	// condition met at capture.
	logic                       branch_link;	// jump writes return address.
	logic [CPU_ADDR_WIDTH-1:0]  pc_p0;			// return address for link.
	logic                       taken_next;		// branch unit decision.

	branch_unit u_branch_unit
	(
		.i_jump   (i_jump),
		.i_rs_val (i_rs_val),
		.i_rt_val (i_rt_val),
		.o_taken  (taken_next)
	);

	// operand select and ALU op, drop does not touch these
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			alu_op <= ALU_ADD;
			a      <= '0;
			b      <= '0;
		end
		else if (!i_stall)
		begin
			alu_op <= i_alu_op;
			case (i_alu_inpt)
				INPT_RTRS:
				begin
					a <= i_rt_val;
					b <= i_rs_val;
				end
				INPT_RSIMM:
				begin
					a <= i_rs_val;
					b <= i_imm;
				end
				INPT_RTIMM:
				begin
					a <= i_rt_val;
					b <= i_imm;
				end
				INPT_PCIMM:
				begin
					a <= i_pc_p1;	// pc relative target.
					b <= i_imm;
				end
				default:
				begin
					a <= i_rs_val;	// INPT_RSRT.
					b <= i_rt_val;
				end
			endcase
		end
	end

	// control state, drop wins over stall
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rd_no        <= REG_R0;
			jump_instr   <= 1'b0;
			branch_taken <= 1'b0;
			branch_link  <= 1'b0;
			o_lsu_op     <= LSU_IDLE;
			o_lsu_ext    <= 1'b0;
		end
		else if (i_drop)
		begin
			rd_no        <= REG_R0;	// no writeback.
			jump_instr   <= 1'b0;
			branch_taken <= 1'b0;	// no redirect.
			o_lsu_op     <= LSU_IDLE;	// no store.
		end
		else if (!i_stall)
		begin
			rd_no        <= i_rd_no;
			jump_instr   <= i_jump != JMP_NONE;
			branch_taken <= taken_next;
			branch_link  <= i_jump_link;
			o_lsu_op     <= i_lsu_op;
			o_lsu_ext    <= i_lsu_ext;
		end
	end

	// payload, meaningful only under the control bits above
	always_ff @(posedge clk)
	begin
		if (!i_stall && !i_drop)
		begin
			pc_p0 <= i_pc_p0;
			if (i_lsu_op != LSU_IDLE)
				o_mem_data <= i_rt_val;	// store data only when needed.
		end
	end

	alu u_alu
	(
		.i_alu_op (alu_op),
		.i_a      (a),
		.i_b      (b),
		.o_result (alu_result)
	);

	assign o_jump_addr  = alu_result;	// target from pc+imm or rs.
	assign o_jump_valid = branch_taken;
	assign o_rd_no      = (jump_instr && !branch_taken) ? REG_R0 : rd_no;	// squash untaken.
	assign o_alu_result = (jump_instr && branch_link) ? pc_p0 : alu_result;

endmodule

// File: design/lsu_stage.sv
module lsu_stage
	import cpu_pkg::*;
(
	input  logic                       clk,
	input  logic                       nrst,
	input  logic                       i_stall,
	input  logic [CPU_REGNO_WIDTH-1:0] i_rd_no,
	input  logic [CPU_REG_WIDTH-1:0]   i_alu_result,
	input  lsu_op_t                    i_lsu_op,
	input  logic                       i_lsu_ext,
	input  logic [CPU_REG_WIDTH-1:0]   i_mem_data,
	input  logic [CPU_REG_WIDTH-1:0]   i_rdata,
	output logic [DMEM_AW-1:0]         o_addr,
	output logic [3:0]                 o_be,
	output logic                       o_we,
	output logic [CPU_REG_WIDTH-1:0]   o_wdata,
	output logic [CPU_REGNO_WIDTH-1:0] o_wb_rd_no,
	output logic [CPU_REG_WIDTH-1:0]   o_wb_data
);

	logic [1:0]               lane;			// byte offset in word.
	logic                     is_store;
	logic                     is_load;
	logic [7:0]               ld_byte;		// addressed byte.
	logic [15:0]              ld_half;		// addressed halfword.
	logic [CPU_REG_WIDTH-1:0] ld_value;		// extended load data.
	logic [CPU_REG_WIDTH-1:0] wb_next;

	assign lane   = i_alu_result[1:0];
	assign o_addr = i_alu_result[DMEM_AW+1:2];	// word address.

	assign is_store = (i_lsu_op == LSU_SB) || (i_lsu_op == LSU_SH) || (i_lsu_op == LSU_SW);
	assign is_load  = (i_lsu_op == LSU_LB) || (i_lsu_op == LSU_LH) || (i_lsu_op == LSU_LW);

	// store lanes, data replicated and enables select
	always_comb
	begin
		case (i_lsu_op)
			LSU_SB:
			begin
				o_be    = 4'b0001 << lane;
				o_wdata = {4{i_mem_data[7:0]}};
			end
			LSU_SH:
			begin
				o_be    = lane[1] ? 4'b1100 : 4'b0011;	// bit 0 ignored.
				o_wdata = {2{i_mem_data[15:0]}};
			end
			LSU_SW:
			begin
				o_be    = 4'b1111;
				o_wdata = i_mem_data;
			end
			default:
			begin
				o_be    = 4'b0000;	// loads and idle.
				o_wdata = i_mem_data;
			end
		endcase
	end

	assign o_we = is_store && !i_stall;	// no write while held.

	// load lane shifted down
	assign ld_byte = i_rdata[8*lane +: 8];
	assign ld_half = lane[1] ? i_rdata[31:16] : i_rdata[15:0];

	always_comb
	begin
		case (i_lsu_op)
			LSU_LB:
				ld_value = {{24{i_lsu_ext & ld_byte[7]}}, ld_byte};
			LSU_LH:
				ld_value = {{16{i_lsu_ext & ld_half[15]}}, ld_half};
			default:
				ld_value = i_rdata;	// LSU_LW.
		endcase
	end

	assign wb_next = is_load ? ld_value : i_alu_result;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_wb_rd_no <= REG_R0;
			o_wb_data  <= '0;
		end
		else if (!i_stall)
		begin
			o_wb_rd_no <= i_rd_no;
			o_wb_data  <= wb_next;
		end
	end

endmodule

// File: verification/tb_exec_mem.sv
module tb_exec_mem
	import cpu_pkg::*;
();

	localparam int PERIOD    = 100;		// clock period.
	localparam int N_PRELOAD = DMEM_WORDS;	// one fill store per word.
	localparam int N_RANDOM  = 3000;

	logic                       clk;
	logic                       nrst;
	logic [CPU_ADDR_WIDTH-1:0]  i_pc_p0;
	logic [CPU_ADDR_WIDTH-1:0]  i_pc_p1;
	logic                       i_stall;
	logic                       i_drop;
	logic [CPU_REGNO_WIDTH-1:0] i_rd_no;
	logic [CPU_REG_WIDTH-1:0]   i_rs_val;
	logic [CPU_REG_WIDTH-1:0]   i_rt_val;
	logic [CPU_REG_WIDTH-1:0]   i_imm;
	alu_op_t                    i_alu_op;
	alu_inpt_t                  i_alu_inpt;
	jump_t                      i_jump;
	logic                       i_jump_link;
	lsu_op_t                    i_lsu_op;
	logic                       i_lsu_ext;
	logic                       o_jump_valid;
	logic [CPU_ADDR_WIDTH-1:0]  o_jump_addr;
	logic [CPU_REGNO_WIDTH-1:0] o_wb_rd_no;
	logic [CPU_REG_WIDTH-1:0]   o_wb_data;

	integer                     seed;
	logic [31:0]                shadow [DMEM_WORDS];	// expected RAM contents.
	logic                       m_jv      = 1'b0;	// execute slot of the model.
	logic [31:0]                m_raw     = '0;		// plain ALU result.
	logic [31:0]                m_res     = '0;		// result after link.
	logic [CPU_REGNO_WIDTH-1:0] m_rd      = REG_R0;
	lsu_op_t                    m_lsu     = LSU_IDLE;
	logic                       m_ext     = 1'b0;
	logic [31:0]                m_sdata   = '0;		// store data.
	logic [CPU_REGNO_WIDTH-1:0] m_wb_rd   = REG_R0;	// writeback slot.
	logic [31:0]                m_wb_data = '0;

	exec_mem_top i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// watchdog, covers reset and drain with margin
	initial
	begin
		#((N_PRELOAD + N_RANDOM + 10) * PERIOD);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("TEST FAILED");
		$fatal(1);
	end

	function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
		case (op)
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_NOR:  return ~(a | b);
			ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return $signed(a) >>> b[4:0];	// sign fill.
			ALU_LUI:  return b << 16;
			default:  return a + b;
		endcase
	endfunction

	function automatic logic taken_model(jump_t j, logic [31:0] rs, logic [31:0] rt);
		case (j)
			JMP_J, JMP_JR: return 1'b1;
			JMP_BLTZ: return $signed(rs) < 0;
			JMP_BGEZ: return $signed(rs) >= 0;
			JMP_BEQ:  return rs == rt;
			JMP_BNE:  return rs != rt;
			JMP_BLEZ: return $signed(rs) <= 0;
			JMP_BGTZ: return $signed(rs) > 0;
			default:  return 1'b0;	// no jump.
		endcase
	endfunction

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// one clock edge of the model, memory slot first
	task automatic advance();
		logic [31:0] word;
		logic        taken;
		int          idx;
		if (!i_stall)
		begin
			idx       = m_res[9:2];	// word address.
			word      = shadow[idx] >> (m_lsu == LSU_LH ? 16 * m_res[1] : 8 * m_res[1:0]);
			m_wb_rd   = m_rd;
			m_wb_data = m_res;
			case (m_lsu)
				LSU_LB: m_wb_data = m_ext ? {{24{word[7]}}, word[7:0]} : {24'h0, word[7:0]};
				LSU_LH: m_wb_data = m_ext ? {{16{word[15]}}, word[15:0]} : {16'h0, word[15:0]};
				LSU_LW: m_wb_data = shadow[idx];	// low bits ignored.
				LSU_SB: shadow[idx][8 * m_res[1:0] +: 8] = m_sdata[7:0];
				LSU_SH: shadow[idx][16 * m_res[1] +: 16] = m_sdata[15:0];
				LSU_SW: shadow[idx] = m_sdata;
				default: ;
			endcase
			case (i_alu_inpt)
				INPT_RTRS:  m_raw = alu_model(i_alu_op, i_rt_val, i_rs_val);
				INPT_RSIMM: m_raw = alu_model(i_alu_op, i_rs_val, i_imm);
				INPT_RTIMM: m_raw = alu_model(i_alu_op, i_rt_val, i_imm);
				INPT_PCIMM: m_raw = alu_model(i_alu_op, i_pc_p1, i_imm);
				default:    m_raw = alu_model(i_alu_op, i_rs_val, i_rt_val);
			endcase
		end
		taken = taken_model(i_jump, i_rs_val, i_rt_val);
		if (i_drop)
		begin
			m_rd  = REG_R0;	// dropped slot is a bubble.
			m_lsu = LSU_IDLE;
			m_jv  = 1'b0;
			m_res = m_raw;
		end
		else if (!i_stall)
		begin
			m_jv  = taken;
			m_rd  = (i_jump != JMP_NONE && !taken) ? REG_R0 : i_rd_no;
			m_res = (i_jump != JMP_NONE && i_jump_link) ? i_pc_p0 : m_raw;	// return pc.
			m_lsu = i_lsu_op;
			m_ext = i_lsu_ext;
			if (i_lsu_op != LSU_IDLE)
				m_sdata = i_rt_val;
		end
	endtask

	// fill store for pre >= 0, random for -1, plain alu op otherwise
	task automatic drive_next(input int pre);
		int          kind;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] pc;
		lsu_op_t     lop;
		kind = (pre >= 0) ? 4 : (pre == -1) ? {$random(seed)} % 4 : 0;	// alu, alu, jump, mem.
		rs   = ({$random(seed)} % 4 == 0) ? 32'h0 : $random(seed);	// zero for blez, bgtz.
		rt   = ({$random(seed)} % 2 == 0) ? rs : $random(seed);	// equal half the time.
		pc   = $random(seed);
		lop  = (kind == 3) ? lsu_op_t'(1 + {$random(seed)} % 6) : LSU_IDLE;
		if (kind == 4)
		begin
			rs  = pre << 2;	// byte address of word pre.
			rt  = {pre[7:0], ~pre[7:0], pre[7:0] ^ 8'h5a, pre[7:0] + 8'd17};
			lop = LSU_SW;
		end
		i_pc_p0     <= pc;
		i_pc_p1     <= pc + 32'd4;
		i_rs_val    <= rs;
		i_rt_val    <= rt;
		i_imm       <= (kind == 4) ? 32'h0 : $random(seed);
		i_alu_op    <= (kind >= 3) ? ALU_ADD : alu_op_t'({$random(seed)} % 12);
		i_alu_inpt  <= (kind >= 3) ? INPT_RSIMM : alu_inpt_t'({$random(seed)} % 5);
		i_jump      <= (kind == 2) ? jump_t'(1 + {$random(seed)} % 8) : JMP_NONE;
		i_jump_link <= (kind == 2) && ($random(seed) % 2 != 0);
		i_lsu_op    <= lop;
		i_lsu_ext   <= $random(seed) % 2 != 0;
		i_rd_no     <= (lop >= LSU_SB) ? REG_R0 : $random(seed);	// stores name r0.
		i_stall     <= (pre == -1) && ({$random(seed)} % 8 == 0);
		i_drop      <= (pre == -1) && ({$random(seed)} % 16 == 0);
	endtask

	task automatic check_outputs();	// sampled at the falling edge.
		assert (o_jump_valid === m_jv) else value_error("o_jump_valid", m_jv, o_jump_valid);
		if (m_jv)
			assert (o_jump_addr === m_raw) else value_error("o_jump_addr", m_raw, o_jump_addr);
		assert (o_wb_rd_no === m_wb_rd) else value_error("o_wb_rd_no", m_wb_rd, o_wb_rd_no);
		assert (o_wb_data === m_wb_data) else value_error("o_wb_data", m_wb_data, o_wb_data);
	endtask

	initial
	begin
		seed = 88080;
		nrst <= 1'b0;
		drive_next(-2);
		repeat (2) @(posedge clk);
		nrst <= 1'b1;	// released after two edges.
		@(negedge clk);
		check_outputs();	// reset values.
		for (int n = 0; n < N_PRELOAD + N_RANDOM + 2; n++)
		begin
			@(posedge clk);
			advance();	// inputs the DUT just sampled.
			drive_next((n < N_PRELOAD) ? n : (n < N_PRELOAD + N_RANDOM) ? -1 : -2);
			@(negedge clk);
			check_outputs();
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: verilog.f
design/cpu_pkg.sv
design/alu.sv
design/branch_unit.sv
design/execute.sv
design/lsu_stage.sv
design/data_ram.sv
design/exec_mem_top.sv
verification/tb_exec_mem.sv
